/* common/lcd_pkg.sv */
package lcd_pkg;

    // One expander write, seen either as the bus byte or as the pin fields
    typedef union packed {
        logic [7:0] raw;            // Byte shifted out MSB first
        struct packed {
            logic [3:0] nibble;     // Display D7..D4
            logic       backlight;
            logic       en;
            logic       rw;
            logic       rs;
        } fields;
    } expander_byte_t;

    localparam logic [6:0] EXPANDER_ADDR = 7'h20;

    localparam int CLK_DIV = 40;    // Clocks per bus bit, sim value

    localparam int DELAY_W = 32;

    localparam logic [DELAY_W-1:0] POWER_WAIT_CYCLES = 32'd1000;
    localparam logic [DELAY_W-1:0] DELAY_LONG        = 32'd2500;  // 50 ms on hardware
    localparam logic [DELAY_W-1:0] DELAY_SHORT       = 32'd500;   // 10 ms
    localparam logic [DELAY_W-1:0] DELAY_CMD         = 32'd50;    // 1 ms
    localparam logic [DELAY_W-1:0] DELAY_CLEAR       = 32'd1000;  // 20 ms

    localparam int NUM_STEPS = 7;
    localparam int STEP_W    = $clog2(NUM_STEPS);

    // Display commands
    localparam logic [7:0] CMD_WAKE       = 8'h30;
    localparam logic [7:0] CMD_FOUR_BIT   = 8'h20;
    localparam logic [7:0] CMD_FUNC_SET   = 8'h28;  // 4 bit, 2 lines, 5x8
    localparam logic [7:0] CMD_DISPLAY_ON = 8'h0C;  // No cursor
    localparam logic [7:0] CMD_CLEAR      = 8'h01;
    localparam logic [7:0] CHAR_CODE      = 8'h41;  // 'A'

    // Sequencer states
    localparam logic [2:0] SEQ_POWER = 3'd0;
    localparam logic [2:0] SEQ_ISSUE = 3'd1;
    localparam logic [2:0] SEQ_WAIT  = 3'd2;
    localparam logic [2:0] SEQ_DELAY = 3'd3;
    localparam logic [2:0] SEQ_DONE  = 3'd4;

    // Bus master states
    localparam logic [2:0] I2C_IDLE  = 3'd0;
    localparam logic [2:0] I2C_START = 3'd1;
    localparam logic [2:0] I2C_ADDR  = 3'd2;
    localparam logic [2:0] I2C_ACK   = 3'd3;
    localparam logic [2:0] I2C_DATA  = 3'd4;
    localparam logic [2:0] I2C_STOP  = 3'd5;

endpackage

/* common/lcd_cmd_if.sv */
`timescale 1ns/1ps

interface lcd_cmd_if;

    logic       start;
    logic [7:0] value;
    logic       rs;
    logic       single;     // Send the high nibble only
    logic       done;

    modport seq (
        output start, value, rs, single,
        input  done
    );

    modport writer (
        input  start, value, rs, single,
        output done
    );

endinterface

/* common/expander_write_if.sv */
`timescale 1ns/1ps

interface expander_write_if;
    import lcd_pkg::*;

    logic           start;
    expander_byte_t data;
    logic           busy;
    logic           done;

    modport writer (
        output start, data,
        input  busy, done
    );

    modport master (
        input  start, data,
        output busy, done
    );

endinterface

/* i2c/i2c_write_master.sv */
`timescale 1ns/1ps

module i2c_write_master (
    input  logic             clk,
    input  logic             rst,
    expander_write_if.master exp,
    output logic             scl,
    output logic             sda_out,
    output logic             sda_en
);
    import lcd_pkg::*;

    logic [2:0]                 state;
    logic [2:0]                 bit_cnt;
    logic [$clog2(CLK_DIV)-1:0] clk_cnt;
    expander_byte_t             data_q;
    logic                       after_addr;  // Ack slot follows the address
    logic [7:0]                 addr_byte;
    logic                       tx_bit;

    assign addr_byte = {EXPANDER_ADDR, 1'b0};  // Write

    always_comb begin
        case (state)
            I2C_ADDR: tx_bit = addr_byte[3'd7 - bit_cnt];
            I2C_DATA: tx_bit = data_q.raw[3'd7 - bit_cnt];
            default:  tx_bit = 1'b1;  // Ack slot, SDA released
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= I2C_IDLE;
            scl        <= 1'b1;
            sda_out    <= 1'b1;
            sda_en     <= 1'b0;
            exp.busy   <= 1'b0;
            exp.done   <= 1'b0;
            bit_cnt    <= '0;
            clk_cnt    <= '0;
            after_addr <= 1'b0;
        end else begin
            exp.done <= 1'b0;
            case (state)
                I2C_IDLE: begin
                    scl    <= 1'b1;
                    sda_en <= 1'b0;
                    if (exp.start) begin
                        exp.busy <= 1'b1;
                        clk_cnt  <= '0;
                        state    <= I2C_START;
                    end
                end
                I2C_START: begin
                    if (clk_cnt < CLK_DIV/2) begin
                        clk_cnt <= clk_cnt + 1'b1;
                        sda_out <= 1'b0;  // SDA falls with SCL high
                        sda_en  <= 1'b1;
                    end else begin
                        clk_cnt <= '0;
                        bit_cnt <= '0;
                        state   <= I2C_ADDR;
                    end
                end
                I2C_ADDR, I2C_ACK, I2C_DATA: begin
                    if (clk_cnt < CLK_DIV/4) begin
                        clk_cnt <= clk_cnt + 1'b1;
                        scl     <= 1'b0;
                        if (clk_cnt != '0) begin  // SDA moves once SCL is low
                            sda_out <= tx_bit;
                            sda_en  <= ~tx_bit;
                        end
                    end else if (clk_cnt < 3*CLK_DIV/4) begin
                        clk_cnt <= clk_cnt + 1'b1;
                        scl     <= 1'b1;
                    end else begin
                        clk_cnt <= '0;
                        if (state == I2C_ACK) begin
                            after_addr <= 1'b0;
                            bit_cnt    <= '0;
                            state      <= after_addr ? I2C_DATA : I2C_STOP;
                        end else if (bit_cnt == 3'd7) begin
                            bit_cnt    <= '0;
                            after_addr <= (state == I2C_ADDR);
                            state      <= I2C_ACK;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                I2C_STOP: begin
                    if (clk_cnt < CLK_DIV/4) begin
                        clk_cnt <= clk_cnt + 1'b1;
                        scl     <= 1'b0;
                        if (clk_cnt != '0) begin
                            sda_out <= 1'b0;
                            sda_en  <= 1'b1;
                        end
                    end else if (clk_cnt < CLK_DIV/2) begin
                        clk_cnt <= clk_cnt + 1'b1;
                        scl     <= 1'b1;
                    end else begin
                        clk_cnt  <= '0;
                        sda_out  <= 1'b1;  // Release, SDA rises with SCL high
                        sda_en   <= 1'b0;
                        exp.done <= 1'b1;
                        exp.busy <= 1'b0;
                        state    <= I2C_IDLE;
                    end
                end
                default: state <= I2C_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == I2C_IDLE && exp.start) begin
            data_q <= exp.data;
        end
    end

endmodule

/* lcd_init/lcd_init_seq.sv */
`timescale 1ns/1ps

module lcd_init_seq (
    input  logic   clk,
    input  logic   rst,
    lcd_cmd_if.seq cmd,
    output logic   init_done
);
    import lcd_pkg::*;

    logic [2:0]         state;
    logic [STEP_W-1:0]  step;
    logic [DELAY_W-1:0] delay_cnt;
    logic [7:0]         step_value;
    logic               step_rs;
    logic               step_single;
    logic [DELAY_W-1:0] step_delay;

    // Step table
    always_comb begin
        step_value  = CMD_WAKE;
        step_rs     = 1'b0;
        step_single = 1'b0;
        step_delay  = DELAY_CMD;
        case (step)
            0: begin
                step_single = 1'b1;
                step_delay  = DELAY_LONG;
            end
            1: begin
                step_single = 1'b1;
                step_delay  = DELAY_SHORT;
            end
            2: begin
                step_value  = CMD_FOUR_BIT;
                step_single = 1'b1;
                step_delay  = DELAY_SHORT;
            end
            3: step_value = CMD_FUNC_SET;
            4: step_value = CMD_DISPLAY_ON;
            5: begin
                step_value = CMD_CLEAR;
                step_delay = DELAY_CLEAR;
            end
            default: begin
                step_value = CHAR_CODE;  // Last step, init_done follows directly
                step_rs    = 1'b1;
                step_delay = '0;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= SEQ_POWER;
            step      <= '0;
            delay_cnt <= '0;
            cmd.start <= 1'b0;
            init_done <= 1'b0;
        end else begin
            cmd.start <= 1'b0;
            case (state)
                SEQ_POWER: begin
                    if (delay_cnt == POWER_WAIT_CYCLES - 1'b1) begin
                        delay_cnt <= '0;
                        state     <= SEQ_ISSUE;
                    end else begin
                        delay_cnt <= delay_cnt + 1'b1;
                    end
                end
                SEQ_ISSUE: begin
                    cmd.start <= 1'b1;
                    state     <= SEQ_WAIT;
                end
                SEQ_WAIT: begin
                    if (cmd.done) begin
                        delay_cnt <= '0;
                        if (step == STEP_W'(NUM_STEPS - 1)) begin
                            init_done <= 1'b1;
                            state     <= SEQ_DONE;
                        end else begin
                            state <= SEQ_DELAY;
                        end
                    end
                end
                SEQ_DELAY: begin
                    if (delay_cnt == step_delay - 1'b1) begin
                        step  <= step + 1'b1;
                        state <= SEQ_ISSUE;
                    end else begin
                        delay_cnt <= delay_cnt + 1'b1;
                    end
                end
                SEQ_DONE: ;  // Idle for good
                default: state <= SEQ_POWER;
            endcase
        end
    end

    // Command fields, valid alongside the start strobe
    always_ff @(posedge clk) begin
        if (state == SEQ_ISSUE) begin
            cmd.value  <= step_value;
            cmd.rs     <= step_rs;
            cmd.single <= step_single;
        end
    end

endmodule

/* lcd_init/lcd_nibble_writer.sv */
`timescale 1ns/1ps

module lcd_nibble_writer (
    input  logic             clk,
    input  logic             rst,
    lcd_cmd_if.writer        cmd,
    expander_write_if.writer exp
);
    import lcd_pkg::*;

    logic           active;
    logic           waiting;     // Write strobed, expecting its done
    logic [1:0]     phase;       // High E=1, high E=0, low E=1, low E=0
    logic [7:0]     value_q;
    logic           rs_q;
    logic           single_q;
    logic           last_phase;
    expander_byte_t wr_byte;

    assign last_phase = single_q ? (phase == 2'd1) : (phase == 2'd3);

    always_comb begin
        wr_byte                  = '0;
        wr_byte.fields.nibble    = phase[1] ? value_q[3:0] : value_q[7:4];
        wr_byte.fields.backlight = 1'b1;
        wr_byte.fields.en        = ~phase[0];
        wr_byte.fields.rw        = 1'b0;
        wr_byte.fields.rs        = rs_q;
    end

    assign exp.data = wr_byte;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            active    <= 1'b0;
            waiting   <= 1'b0;
            phase     <= '0;
            exp.start <= 1'b0;
            cmd.done  <= 1'b0;
        end else begin
            exp.start <= 1'b0;
            cmd.done  <= 1'b0;
            if (!active) begin
                if (cmd.start) begin
                    active  <= 1'b1;
                    waiting <= 1'b0;
                    phase   <= '0;
                end
            end else if (!waiting) begin
                if (!exp.busy) begin
                    exp.start <= 1'b1;
                    waiting   <= 1'b1;
                end
            end else if (exp.done) begin
                waiting <= 1'b0;
                if (last_phase) begin
                    active   <= 1'b0;
                    cmd.done <= 1'b1;
                end else begin
                    phase <= phase + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!active && cmd.start) begin
            value_q  <= cmd.value;
            rs_q     <= cmd.rs;
            single_q <= cmd.single;
        end
    end

endmodule

/* src/lcd_i2c_top.sv */
`timescale 1ns/1ps

module lcd_i2c_top (
    input  logic clk,
    input  logic rst,
    output logic scl,
    inout  wire  sda,
    output logic init_done
);

    logic sda_out;
    logic sda_en;

    lcd_cmd_if        cmd_if ();
    expander_write_if exp_if ();

    lcd_init_seq lcd_init_seq_i (
        .clk       (clk),
        .rst       (rst),
        .cmd       (cmd_if.seq),
        .init_done (init_done)
    );

    lcd_nibble_writer lcd_nibble_writer_i (
        .clk (clk),
        .rst (rst),
        .cmd (cmd_if.writer),
        .exp (exp_if.writer)
    );

    i2c_write_master i2c_write_master_i (
        .clk     (clk),
        .rst     (rst),
        .exp     (exp_if.master),
        .scl     (scl),
        .sda_out (sda_out),
        .sda_en  (sda_en)
    );

    assign sda = (sda_en && !sda_out) ? 1'b0 : 1'bz;  // Open drain, pulled up outside

endmodule

/* verif/lcd_i2c_tb.sv */
`timescale 1ns/1ps

module lcd_i2c_tb;
    import lcd_pkg::*;

    localparam int XFER_MAX     = 22;
    localparam int WRITE_CYCLES = 2 * (CLK_DIV/2 + 1) + 18 * (3*CLK_DIV/4 + 1);

    logic clk;
    logic rst;
    logic scl;
    logic init_done;
    wire  sda;

    logic [31:0] file_words [0:3*XFER_MAX];  // Transfer count and then addr, data and gap
    int          n_xfer;
    int          timeout_cycles = 0;
    int          cycle_cnt = 0;

    logic        prev_scl;
    logic        prev_sda;
    logic [8:0]  shift_reg;  // 8 bits plus the ack slot
    int          bit_idx;
    int          byte_idx;
    int          start_cnt = 0;
    int          stop_cnt = 0;
    int          idle_cnt;

    pullup (sda);  // Stands in for the bus pull-up resistor

    lcd_i2c_top lcd_i2c_top_i (
        .clk       (clk),
        .rst       (rst),
        .scl       (scl),
        .sda       (sda),
        .init_done (init_done)
    );

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("Checks failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_byte(input string name, input expander_byte_t expected,
                              input expander_byte_t actual);
        if (actual.raw !== expected.raw) begin
            $display("ERROR at %0t ns: %s expected %h, got %h", $time, name,
                     expected.raw, actual.raw);
            abort_run("byte mismatch on the bus");
        end
    endtask

    task automatic check_level(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("ERROR at %0t ns: %s expected %b, got %b", $time, name, expected, actual);
            abort_run("level mismatch");
        end
    endtask

    task automatic idle_bus_levels();
        check_level("scl", 1'b1, scl);
        check_level("sda", 1'b1, sda);
        check_level("init_done", 1'b0, init_done);
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (timeout_cycles > 0 && cycle_cnt > timeout_cycles) begin
            abort_run($sformatf("timeout: init sequence not finished after %0d cycles",
                                cycle_cnt));
        end
    end

    // Bus decoder sampling mid-cycle where scl and sda are stable
    always @(negedge clk) begin
        expander_byte_t got;
        expander_byte_t want;
        if (rst) begin
            prev_scl = 1'b1;
            prev_sda = 1'b1;
            idle_cnt = 0;
            bit_idx  = 0;
            byte_idx = 0;
        end else begin
            idle_cnt = idle_cnt + 1;
            if (prev_scl && scl && prev_sda && !sda) begin  // Start
                if (start_cnt >= n_xfer) begin
                    abort_run("a start condition appeared after the last expected transfer");
                end
                if (idle_cnt < file_words[3*start_cnt + 3]) begin
                    abort_run($sformatf("transfer %0d began %0d cycles after the last, %0s %0d",
                                        start_cnt, idle_cnt, "expected at least",
                                        file_words[3*start_cnt + 3]));
                end
                check_level("init_done", 1'b0, init_done);
                start_cnt = start_cnt + 1;
                bit_idx   = 0;
                byte_idx  = 0;
            end else if (prev_scl && scl && !prev_sda && sda) begin  // Stop
                if (byte_idx != 2) begin
                    abort_run("a stop condition came before both bytes of a transfer");
                end
                check_level("init_done", 1'b0, init_done);
                stop_cnt = stop_cnt + 1;
                idle_cnt = 0;
            end else if (!prev_scl && scl && start_cnt > 0) begin
                shift_reg = {shift_reg[7:0], sda};
                bit_idx   = bit_idx + 1;
                if (bit_idx == 9 && byte_idx < 2) begin
                    got.raw  = shift_reg[8:1];
                    want.raw = file_words[3*(start_cnt-1) + 1 + byte_idx][7:0];
                    if (byte_idx == 0) begin
                        check_byte("address byte", want, got);
                    end else begin
                        check_byte("data byte", want, got);
                    end
                    byte_idx = byte_idx + 1;
                    bit_idx  = 0;
                end
            end
            prev_scl = scl;
            prev_sda = sda;
        end
    end

    initial begin
        int gap_sum;
        int k;
        rst = 1'b1;
        n_xfer = XFER_MAX;
        $readmemh("verif/lcd_i2c_input.txt", file_words);
        if (file_words[0] === 'x || file_words[0] != XFER_MAX) begin
            abort_run("data file missing or holding a wrong transfer count");
        end
        n_xfer  = file_words[0];
        gap_sum = 0;
        for (k = 0; k < n_xfer; k++) begin
            gap_sum = gap_sum + file_words[3*k + 3];
        end
        // All writes and delays plus one trailing write and a quarter margin
        timeout_cycles = (gap_sum + (n_xfer + 1) * WRITE_CYCLES) * 5 / 4 + 4;

        repeat (4) begin
            @(posedge clk);
            #1;
            idle_bus_levels();
        end
        rst = 1'b0;

        repeat (file_words[3]) begin  // Power wait
            @(negedge clk);
            idle_bus_levels();
        end
        if (start_cnt != 0) begin
            abort_run("the bus started a transfer during the power-on wait");
        end

        wait (stop_cnt == n_xfer);
        k = 0;
        while (!init_done && k < 8) begin
            @(negedge clk);
            k = k + 1;
        end
        check_level("init_done", 1'b1, init_done);

        repeat (WRITE_CYCLES) begin  // Nothing more may follow
            @(negedge clk);
            check_level("init_done", 1'b1, init_done);
        end
        if (start_cnt != n_xfer) begin
            abort_run("the number of transfers differs from the data file");
        end
        $display("All checks passed");
        $finish;
    end

endmodule

/* verif/lcd_i2c_input.txt */
// First word: number of transfers (hex)
// Then one line per transfer: address byte, data byte, min idle cycles before it (hex)
16
// Wake-up 0x3, after the power wait
40 3C 3E8
40 38 0
// Wake-up 0x3, after the long delay
40 3C 9C4
40 38 0
// Four-bit mode 0x2
40 2C 1F4
40 28 0
// Function set 0x28
40 2C 1F4
40 28 0
40 8C 0
40 88 0
// Display on 0x0C
40 0C 32
40 08 0
40 CC 0
40 C8 0
// Clear 0x01
40 0C 32
40 08 0
40 1C 0
40 18 0
// Character 'A' with RS set, after the clear delay
40 4D 3E8
40 49 0
40 1D 0
40 19 0

/* lcd_i2c.f */
common/lcd_pkg.sv
common/lcd_cmd_if.sv
common/expander_write_if.sv
i2c/i2c_write_master.sv
lcd_init/lcd_init_seq.sv
lcd_init/lcd_nibble_writer.sv
src/lcd_i2c_top.sv
verif/lcd_i2c_tb.sv

/* Bender.yml */
package:
  name: lcd_i2c

sources:
  - common/lcd_pkg.sv
  - common/lcd_cmd_if.sv
  - common/expander_write_if.sv
  - i2c/i2c_write_master.sv
  - lcd_init/lcd_init_seq.sv
  - lcd_init/lcd_nibble_writer.sv
  - src/lcd_i2c_top.sv
  - target: test
    files:
      - verif/lcd_i2c_tb.sv
